// File: build.f
+incdir+include
hdl/counter_types_pkg.sv
hdl/pattern_types_pkg.sv
hdl/count_step_if.sv
hdl/count_control.sv
hdl/count_datapath.sv
hdl/pattern_source.sv
hdl/trigger_monitor.sv
hdl/counter_host_top.sv
sim/counter_host_properties.sv
sim/counter_host_checker.sv
sim/counter_host_tb.sv

// File: hdl/count_control.sv
// ======================================================================
// Strobe and forced clear decode into a single counter opcode,
// plus the pattern advance enable
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

`include "counter_config.svh"

module count_control
    import counter_types_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  count_enable,
    input  wire logic                  count_direction,  // 0 up, 1 down
    input  wire logic                  load_counter,
    input  wire logic [`CNT_WIDTH-1:0] load_value,
    input  wire logic                  force_clear,
    count_step_if.control              step,
    output logic                       pattern_step
);

    logic clear_busy;  // Counter is taking up a forced clear

    // Priority: clear, load, count, hold
    always_comb begin
        if (force_clear) begin
            step.op = OP_CLEAR;
        end else if (load_counter) begin
            step.op = OP_LOAD;
        end else if (count_enable) begin
            step.op = count_direction ? OP_DOWN : OP_UP;
        end else begin
            step.op = OP_HOLD;
        end
    end

    assign step.load_value = load_value;

    // Set for the cycle after an OP_CLEAR edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clear_busy <= 1'b0;
        end else begin
            clear_busy <= (step.op == OP_CLEAR);
        end
    end

    // LFSR rests while the clear settles
    assign pattern_step = count_enable & ~clear_busy;

endmodule

`default_nettype wire

// File: hdl/count_datapath.sv
// ======================================================================
// Counter register with wrap, status flags and output register
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

`include "counter_config.svh"

module count_datapath
    import counter_types_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst,
    count_step_if.datapath          step,
    output logic [`CNT_WIDTH-1:0]   counter_value,
    output count_flags_t            flags
);

    localparam int CNT_W = `CNT_WIDTH;
    localparam logic [CNT_W-1:0] COUNT_TOP = CNT_W'(`CNT_MAX - 1);

    logic [CNT_W-1:0] counter;
    logic [CNT_W-1:0] next_count;
    count_flags_t     next_flags;

    // Next value and flags for the presented opcode
    always_comb begin
        next_count = counter;
        next_flags = flags;  // Hold keeps everything
        case (step.op)
            OP_CLEAR: begin
                next_count = '0;
            end
            OP_LOAD: begin
                next_count = step.load_value;
            end
            OP_UP: begin
                next_count = (counter == COUNT_TOP) ? '0 : counter + 1'b1;
            end
            OP_DOWN: begin
                next_count = (counter == '0) ? COUNT_TOP : counter - 1'b1;
            end
            default: begin
                next_count = counter;
            end
        endcase

        if (step.op != OP_HOLD) begin
            next_flags.overflow  = (step.op == OP_UP) && (counter == COUNT_TOP);
            next_flags.underflow = (step.op == OP_DOWN) && (counter == '0);
            next_flags.zero      = (next_count == '0);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            counter <= '0;
            flags   <= '{overflow: 1'b0, underflow: 1'b0, zero: 1'b1};
        end else begin
            counter <= next_count;
            flags   <= next_flags;
        end
    end

    // Output stage, one cycle behind the counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            counter_value <= '0;
        end else if (step.op == OP_CLEAR) begin
            counter_value <= '0;  // Clear hits both stages at once
        end else begin
            counter_value <= counter;
        end
    end

    assign step.count   = counter;
    assign step.wrapped = flags.overflow | flags.underflow;

endmodule

`default_nettype wire

// File: hdl/count_step_if.sv
// ======================================================================
// Opcode and counter status link between control and datapath
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

`include "counter_config.svh"

interface count_step_if
    import counter_types_pkg::*;
    ();

    count_op_t              op;          // Valid every cycle
    logic [`CNT_WIDTH-1:0]  load_value;
    logic [`CNT_WIDTH-1:0]  count;       // Current counter register
    logic                   wrapped;     // Registered overflow or underflow

    modport control (
        output op,
        output load_value
    );

    modport datapath (
        input  op,
        input  load_value,
        output count,
        output wrapped
    );

endinterface

`default_nettype wire

// File: hdl/counter_host_top.sv
// ======================================================================
// Event counter top level with pattern-triggered clear
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

`include "counter_config.svh"

module counter_host_top
    import counter_types_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  count_enable,
    input  wire logic                  count_direction,
    input  wire logic                  load_counter,
    input  wire logic [`CNT_WIDTH-1:0] load_value,
    output logic [`CNT_WIDTH-1:0]      counter_value,
    output logic                       counter_overflow,
    output logic                       counter_underflow,
    output logic                       counter_zero
);

    count_flags_t flags;
    logic         pattern_step;
    logic [7:0]   sample_byte;
    logic         force_clear;

    count_step_if step ();

    count_control count_control_inst (
        .clk             (clk),
        .rst             (rst),
        .count_enable    (count_enable),
        .count_direction (count_direction),
        .load_counter    (load_counter),
        .load_value      (load_value),
        .force_clear     (force_clear),
        .step            (step.control),
        .pattern_step    (pattern_step)
    );

    count_datapath count_datapath_inst (
        .clk           (clk),
        .rst           (rst),
        .step          (step.datapath),
        .counter_value (counter_value),
        .flags         (flags)
    );

    pattern_source pattern_source_inst (
        .clk          (clk),
        .rst          (rst),
        .pattern_step (pattern_step),
        .count        (step.count),
        .wrapped      (step.wrapped),
        .sample_byte  (sample_byte)
    );

    // Samples on the same strobe that advances the LFSR
    trigger_monitor trigger_monitor_inst (
        .clk          (clk),
        .rst          (rst),
        .sample_byte  (sample_byte),
        .sample_valid (pattern_step),
        .force_clear  (force_clear)
    );

    assign counter_overflow  = flags.overflow;
    assign counter_underflow = flags.underflow;
    assign counter_zero      = flags.zero;

endmodule

`default_nettype wire

// File: hdl/counter_types_pkg.sv
// ======================================================================
// Counter opcode and status flag types
// ======================================================================
`default_nettype none

package counter_types_pkg;

    // One operation per cycle, resolved by count_control
    typedef enum logic [2:0] {
        OP_HOLD  = 3'd0,
        OP_CLEAR = 3'd1,
        OP_LOAD  = 3'd2,
        OP_UP    = 3'd3,
        OP_DOWN  = 3'd4
    } count_op_t;

    typedef struct packed {
        logic overflow;   // Up-count wrapped to zero
        logic underflow;  // Down-count wrapped to top
        logic zero;
    } count_flags_t;

endpackage

`default_nettype wire

// File: hdl/pattern_source.sv
// ======================================================================
// Pattern LFSR, byte view selector and sample byte mux
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

`include "counter_config.svh"

module pattern_source
    import pattern_types_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  pattern_step,
    input  wire logic [`CNT_WIDTH-1:0] count,
    input  wire logic                  wrapped,
    output logic [7:0]                 sample_byte
);

    logic [`PAT_WIDTH-1:0] lfsr;
    byte_view_t            view_sel;
    logic                  feedback;
    logic                  view_advance;

    assign feedback = lfsr[27] ^ lfsr[22] ^ lfsr[16] ^ lfsr[3];

    // Rotate views on a wrap or every 16th count
    assign view_advance = wrapped || (count[3:0] == 4'h0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr     <= `PAT_SEED;
            view_sel <= VIEW_B0;
        end else if (pattern_step) begin
            lfsr <= {lfsr[`PAT_WIDTH-2:0], feedback};
            if (view_advance) begin
                view_sel <= byte_view_t'(view_sel + 3'd1);  // 7 wraps to 0
            end
        end
    end

    always_comb begin
        case (view_sel)
            VIEW_B0:  sample_byte = lfsr[7:0];
            VIEW_B1:  sample_byte = lfsr[15:8];
            VIEW_B2:  sample_byte = lfsr[23:16];
            VIEW_B3:  sample_byte = lfsr[27:20];  // Overlaps B2 by four bits
            VIEW_X01: sample_byte = lfsr[7:0] ^ lfsr[15:8];
            VIEW_X20: sample_byte = lfsr[23:16] ^ lfsr[7:0];
            VIEW_X31: sample_byte = lfsr[27:20] ^ lfsr[15:8];
            VIEW_X30: sample_byte = lfsr[27:20] ^ lfsr[7:0];
            default:  sample_byte = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/pattern_types_pkg.sv
// ======================================================================
// Byte view select and trigger monitor state types
// ======================================================================
`default_nettype none

package pattern_types_pkg;

    // Eight views of the LFSR, plain bytes first, then XOR pairs
    typedef enum logic [2:0] {
        VIEW_B0, VIEW_B1, VIEW_B2, VIEW_B3,
        VIEW_X01, VIEW_X20, VIEW_X31, VIEW_X30
    } byte_view_t;

    typedef enum logic [1:0] {
        TRIG_IDLE  = 2'd0,
        TRIG_ARMED = 2'd1,  // One match seen
        TRIG_FIRE  = 2'd2   // Clear pulse cycle
    } trig_state_t;

endpackage

`default_nettype wire

// File: hdl/trigger_monitor.sv
// ======================================================================
// Two-match trigger FSM driving the forced clear pulse
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

`include "counter_config.svh"

module trigger_monitor
    import pattern_types_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic [7:0] sample_byte,
    input  wire logic       sample_valid,
    output logic            force_clear
);

    trig_state_t state;
    trig_state_t state_next;
    logic        match;

    assign match = ((sample_byte & `TRIG_MASK) == `TRIG_VALUE);

    always_comb begin
        state_next = state;
        case (state)
            TRIG_IDLE: begin
                if (sample_valid && match) begin
                    state_next = TRIG_ARMED;
                end
            end
            TRIG_ARMED: begin
                if (sample_valid) begin
                    state_next = match ? TRIG_FIRE : TRIG_IDLE;
                end
            end
            // Single pulse, then start over
            default: state_next = TRIG_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= TRIG_IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign force_clear = (state == TRIG_FIRE);

endmodule

`default_nettype wire

// File: include/counter_config.svh
// ======================================================================
// Build constants for the event counter and its pattern trigger
// ======================================================================
`ifndef COUNTER_CONFIG_SVH
`define COUNTER_CONFIG_SVH

// Counter sizing
`define CNT_WIDTH   12
`define CNT_MAX     2048          // Wrap limit, top count is CNT_MAX-1

// Pattern generator
`define PAT_WIDTH   28
`define PAT_SEED    28'hFEEDBEE   // LFSR value out of reset

// Trigger match on the selected byte
`define TRIG_MASK   8'h0F
`define TRIG_VALUE  8'h0A

`endif

// File: run_sim.sh
#!/bin/sh
# Build and run the counter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module counter_host_tb -o counter_host_sim > build.log 2>&1 \
    || { echo "compile failed, see build.log"; exit 1; }

./obj_dir/counter_host_sim > sim.log 2>&1 ; cat sim.log

grep -q "TB FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "simulation did not finish"; exit 1; }
exit 0

// File: sim/counter_host_checker.sv
// ======================================================================
// Reference model of counter, LFSR, selector and trigger,
// with per-segment compare and report
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

`include "counter_config.svh"

module counter_host_checker (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  count_enable,
    input  wire logic                  count_direction,
    input  wire logic                  load_counter,
    input  wire logic [`CNT_WIDTH-1:0] load_value,
    input  wire logic [`CNT_WIDTH-1:0] counter_value,
    input  wire logic                  counter_overflow,
    input  wire logic                  counter_underflow,
    input  wire logic                  counter_zero,
    input  wire logic [127:0]          seg_name,
    input  wire logic                  seg_last,
    output int                         error_total,
    output int                         clear_total,
    output int                         seg_total
);

    localparam logic [11:0] TOP = 12'(`CNT_MAX - 1);

    // Model state
    logic [11:0]            m_cnt;
    logic [11:0]            m_cval;
    logic                   m_ov;
    logic                   m_un;
    logic                   m_zero;
    logic [`PAT_WIDTH-1:0]  m_lfsr;
    logic [2:0]             m_view;
    logic [1:0]             m_trig;   // 0 idle, 1 armed, 2 fire
    logic                   m_busy;

    logic [127:0]           cur_name;
    logic                   report_pending;
    logic                   active;
    int                     seg_errors;
    int                     seg_cycles;

    // Temporaries of the model step
    logic        t_clear;
    logic        t_pstep;
    logic        t_match;
    logic [7:0]  t_byte;
    logic [11:0] t_next;

    function automatic logic [7:0] view_byte(input logic [27:0] r, input logic [2:0] v);
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        b0 = r[7:0];
        b1 = r[15:8];
        b2 = r[23:16];
        b3 = r[27:20];
        case (v)
            3'd0: return b0;
            3'd1: return b1;
            3'd2: return b2;
            3'd3: return b3;
            3'd4: return b0 ^ b1;
            3'd5: return b2 ^ b0;
            3'd6: return b3 ^ b1;
            default: return b3 ^ b0;
        endcase
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            m_cnt <= '0;
            m_cval <= '0;
            m_ov <= 1'b0;
            m_un <= 1'b0;
            m_zero <= 1'b1;
            m_lfsr <= `PAT_SEED;
            m_view <= 3'd0;
            m_trig <= 2'd0;
            m_busy <= 1'b0;
            active <= 1'b0;
            report_pending <= 1'b0;
        end else begin
            t_clear = (m_trig == 2'd2);
            t_pstep = count_enable && !m_busy;
            t_byte  = view_byte(m_lfsr, m_view);
            t_match = ((t_byte & `TRIG_MASK) == `TRIG_VALUE);

            // Trigger FSM
            case (m_trig)
                2'd0: m_trig <= (t_pstep && t_match) ? 2'd1 : 2'd0;
                2'd1: m_trig <= t_pstep ? (t_match ? 2'd2 : 2'd0) : 2'd1;
                default: m_trig <= 2'd0;
            endcase

            // Clear beats load and load beats count
            if (t_clear) begin
                t_next = '0;
                clear_total = clear_total + 1;
            end else if (load_counter) begin
                t_next = load_value;
            end else if (count_enable && !count_direction) begin
                t_next = (m_cnt == TOP) ? 12'd0 : m_cnt + 12'd1;
            end else if (count_enable) begin
                t_next = (m_cnt == 12'd0) ? TOP : m_cnt - 12'd1;
            end else begin
                t_next = m_cnt;
            end
            if (t_clear || load_counter || count_enable) begin
                m_ov <= !t_clear && !load_counter && !count_direction && (m_cnt == TOP);
                m_un <= !t_clear && !load_counter && count_direction && (m_cnt == 12'd0);
                m_zero <= (t_next == 12'd0);
            end
            m_cnt <= t_next;
            m_cval <= t_clear ? 12'd0 : m_cnt;

            if (t_pstep) begin
                m_lfsr <= {m_lfsr[26:0], m_lfsr[27] ^ m_lfsr[22] ^ m_lfsr[16] ^ m_lfsr[3]};
                if (m_ov || m_un || m_cnt[3:0] == 4'h0) begin
                    m_view <= m_view + 3'd1;
                end
            end
            m_busy <= t_clear;

            cur_name <= seg_name;
            report_pending <= seg_last;
            active <= 1'b1;
        end
    end

    task automatic check_value(input string field, input logic [11:0] exp_v,
                               input logic [11:0] act_v);
        if (exp_v !== act_v) begin
            $display("mismatch test=%0s %0s expected 0x%03h actual 0x%03h",
                     cur_name, field, exp_v, act_v);
            seg_errors = seg_errors + 1;
            error_total = error_total + 1;
        end
    endtask

    initial begin
        error_total = 0;
        clear_total = 0;
        seg_total = 0;
        seg_errors = 0;
        seg_cycles = 0;
    end

    // Outputs are stable half a cycle after the edge
    always @(negedge clk) begin
        if (active && !rst) begin
            check_value("counter_value", m_cval, counter_value);
            check_value("overflow", {11'd0, m_ov}, {11'd0, counter_overflow});
            check_value("underflow", {11'd0, m_un}, {11'd0, counter_underflow});
            check_value("zero", {11'd0, m_zero}, {11'd0, counter_zero});
            seg_cycles = seg_cycles + 1;
            if (report_pending) begin
                $display("test %0s: %0d cycles, %0d mismatches, %0s", cur_name,
                         seg_cycles, seg_errors, (seg_errors == 0) ? "ok" : "failed");
                seg_total = seg_total + 1;
                seg_errors = 0;
                seg_cycles = 0;
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/counter_host_properties.sv
// ======================================================================
// Bound assertions on counter flags and forced clear behavior
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

`include "counter_config.svh"

module counter_host_properties
    import counter_types_pkg::*;
(
    input wire logic                  clk,
    input wire logic                  rst,
    input wire count_op_t             op,
    input wire logic [`CNT_WIDTH-1:0] counter,
    input wire count_flags_t          flags
);

    // Both wrap directions can not happen at once
    assert property (@(posedge clk) disable iff (rst)
        !(flags.overflow && flags.underflow))
        else $error("overflow and underflow high together");

    // A forced clear is a single cycle pulse
    assert property (@(posedge clk) disable iff (rst)
        (op == OP_CLEAR) |=> (op != OP_CLEAR))
        else $error("forced clear lasted two cycles");

    assert property (@(posedge clk) disable iff (rst)
        (op == OP_CLEAR) |=> (counter == '0 && flags.zero
                              && !flags.overflow && !flags.underflow))
        else $error("counter not zero after forced clear");

endmodule

bind count_datapath counter_host_properties counter_host_properties_inst (
    .clk     (clk),
    .rst     (rst),
    .op      (step.op),
    .counter (counter),
    .flags   (flags)
);

`default_nettype wire

// File: sim/counter_host_tb.sv
// ======================================================================
// Testbench for the event counter, segment table, clock and timeout
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

`include "counter_config.svh"

module counter_host_tb;

    localparam int NUM_SEGS = 11;
    localparam int M_LOAD_HOLD = 0;
    localparam int M_LOAD_UP = 1;
    localparam int M_LOAD_DOWN = 2;
    localparam int M_UP_HOLD = 3;
    localparam int M_PRIORITY = 4;
    localparam int M_RANDOM = 5;
    localparam int M_VIEW_SWEEP = 6;

    logic                  clk;
    logic                  rst;
    logic                  count_enable;
    logic                  count_direction;
    logic                  load_counter;
    logic [`CNT_WIDTH-1:0] load_value;
    logic [`CNT_WIDTH-1:0] counter_value;
    logic                  counter_overflow;
    logic                  counter_underflow;
    logic                  counter_zero;

    logic [127:0] seg_name;
    logic         seg_last;
    int           error_total;
    int           clear_total;
    int           seg_total;

    // Segment table
    logic [127:0] tbl_name [NUM_SEGS];
    int           tbl_mode [NUM_SEGS];
    logic [11:0]  tbl_start [NUM_SEGS];
    int           tbl_cycles [NUM_SEGS];

    int cycle_count;
    int cycle_limit;

    counter_host_top counter_host_top_inst (
        .clk               (clk),
        .rst               (rst),
        .count_enable      (count_enable),
        .count_direction   (count_direction),
        .load_counter      (load_counter),
        .load_value        (load_value),
        .counter_value     (counter_value),
        .counter_overflow  (counter_overflow),
        .counter_underflow (counter_underflow),
        .counter_zero      (counter_zero)
    );

    counter_host_checker counter_host_checker_inst (
        .clk               (clk),
        .rst               (rst),
        .count_enable      (count_enable),
        .count_direction   (count_direction),
        .load_counter      (load_counter),
        .load_value        (load_value),
        .counter_value     (counter_value),
        .counter_overflow  (counter_overflow),
        .counter_underflow (counter_underflow),
        .counter_zero      (counter_zero),
        .seg_name          (seg_name),
        .seg_last          (seg_last),
        .error_total       (error_total),
        .clear_total       (clear_total),
        .seg_total         (seg_total)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic add_segment(input int idx, input logic [127:0] name, input int mode,
                               input logic [11:0] start, input int cycles);
        tbl_name[idx] = name;
        tbl_mode[idx] = mode;
        tbl_start[idx] = start;
        tbl_cycles[idx] = cycles;
    endtask

    // Inputs for one cycle of a segment
    task automatic drive_cycle(input int mode, input logic [11:0] start, input int idx);
        count_enable = 1'b0;
        count_direction = 1'b0;
        load_counter = 1'b0;
        load_value = 12'($urandom) & 12'h7FF;  // Keep loads inside the count range
        case (mode)
            M_LOAD_HOLD: begin
                load_counter = (idx == 0);
                load_value = start;
            end
            M_LOAD_UP, M_LOAD_DOWN: begin
                load_counter = (idx == 0);
                load_value = start;
                count_enable = 1'b1;
                count_direction = (mode == M_LOAD_DOWN);
            end
            M_UP_HOLD: begin
                load_counter = (idx == 0);
                load_value = start;
                count_enable = (idx < 3);
            end
            M_PRIORITY: begin
                count_enable = 1'b1;
                count_direction = $urandom % 2;
                load_counter = (idx % 2 == 0);  // Load must beat the step
            end
            M_VIEW_SWEEP: begin
                count_enable = 1'b1;
                count_direction = $urandom % 2;
                load_counter = 1'b1;
                load_value = load_value & 12'h7F0;  // Low nibble zero moves the view each cycle
            end
            default: begin
                count_enable = ($urandom % 4) != 0;
                count_direction = $urandom % 2;
                load_counter = ($urandom % 32) == 0;
            end
        endcase
    endtask

    initial begin
        rst = 1'b1;
        count_enable = 1'b0;
        count_direction = 1'b0;
        load_counter = 1'b0;
        load_value = '0;
        seg_name = '0;
        seg_last = 1'b0;
        cycle_count = 0;
        void'($urandom(32'h6a8f_6ea6));

        add_segment(0, "load_mid", M_LOAD_HOLD, 12'h5A5, 6);
        add_segment(1, "load_zero", M_LOAD_HOLD, 12'h000, 6);
        add_segment(2, "up_wrap", M_LOAD_UP, 12'd2046, 8);
        add_segment(3, "down_wrap", M_LOAD_DOWN, 12'd1, 8);
        add_segment(4, "load_top_up", M_LOAD_UP, 12'd2047, 5);
        add_segment(5, "hold_flags", M_UP_HOLD, 12'd2046, 8);
        add_segment(6, "priority", M_PRIORITY, 12'd0, 20);
        add_segment(7, "down_run", M_LOAD_DOWN, 12'h010, 300);
        add_segment(8, "random_a", M_RANDOM, 12'd0, 800);
        add_segment(9, "random_b", M_RANDOM, 12'd0, 1200);
        add_segment(10, "view_sweep", M_VIEW_SWEEP, 12'd0, 2000);

        cycle_limit = 20;
        for (int s = 0; s < NUM_SEGS; s++) begin
            cycle_limit = cycle_limit + tbl_cycles[s];
        end

        repeat (2) @(posedge clk);
        #5 rst = 1'b0;

        for (int s = 0; s < NUM_SEGS; s++) begin
            for (int c = 0; c < tbl_cycles[s]; c++) begin
                @(posedge clk);
                #5;
                seg_name = tbl_name[s];
                seg_last = (c == tbl_cycles[s] - 1);
                drive_cycle(tbl_mode[s], tbl_start[s], c);
            end
        end

        // Idle tail so the last segment is compared and reported
        @(posedge clk);
        #5;
        seg_last = 1'b0;
        seg_name = "idle";
        count_enable = 1'b0;
        load_counter = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);

        if (clear_total == 0) begin
            $display("the model predicted no forced clear, trigger never exercised");
        end
        $display("summary: %0d tests, %0d mismatches, %0d forced clears",
                 seg_total, error_total, clear_total);
        if (error_total == 0 && clear_total != 0 && seg_total == NUM_SEGS) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not end within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire
